//--- source/snes_mem_pkg.sv
package snes_mem_pkg;

    // Core side address widths
    localparam int rom_addr_w  = 23;               // 8 MB ROM byte space
    localparam int wram_addr_w = 17;               // 128 KB WRAM

    // SDRAM CPU port is word addressed
    localparam int word_addr_w = rom_addr_w - 1;

    localparam int data_w = 16;                    // SDRAM port word
    localparam int byte_w = 8;                     // Core data bus
    localparam int ds_w   = 2;                     // One select per byte lane

    // WRAM lives in the last 128 KB of SDRAM, 7E:0000 to 7F:FFFF
    localparam int wram_bank_w = rom_addr_w - wram_addr_w;
    localparam logic [wram_bank_w-1:0] wram_bank = {wram_bank_w{1'b1}};

    // Which result port the SDRAM answers on
    localparam logic port_rom  = 1'b0;
    localparam logic port_wram = 1'b1;

endpackage

//--- source/rom_channel.sv
module rom_channel import snes_mem_pkg::*; (
    input  logic                  mclk,
    input  logic                  resetn,

    // ROM loader byte stream
    input  logic                  loading,
    input  logic [byte_w-1:0]     loader_do,
    input  logic                  loader_do_valid,

    // Core ROM bus
    input  logic [rom_addr_w-1:0] rom_addr,
    input  logic                  rom_ce_n,

    input  logic                  sdram_busy,

    // Request pulse toward the port mux
    output logic                  rom_hit,
    output logic [rom_addr_w-1:0] rom_hit_addr,
    output logic                  rom_hit_we,
    output logic [data_w-1:0]     rom_hit_din,

    output logic                  loaded,
    output logic                  enable
);

    logic [rom_addr_w-1:0] loader_addr;    // Byte count of the image so far
    logic [byte_w-1:0]     loader_do_r;    // Even byte waiting for its partner
    logic                  loading_r;
    logic [rom_addr_w-1:0] rom_addr_sd;    // Last address sent to SDRAM

    logic load_wr;
    logic rom_rd;

    // Write once both bytes of a word are in, i.e. on the odd byte
    assign load_wr = loading && loader_do_valid && loader_addr[0];

    // Only fetch when the core moves to a new address
    assign rom_rd = !loading && !rom_ce_n && (rom_addr != rom_addr_sd);

    assign rom_hit      = load_wr || rom_rd;
    assign rom_hit_we   = loading;
    assign rom_hit_addr = loading ? loader_addr : rom_addr;
    assign rom_hit_din  = {loader_do, loader_do_r};   // Odd byte goes high

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r   <= 1'b0;
            loaded      <= 1'b0;
            loader_addr <= '0;
            rom_addr_sd <= '0;
        end else begin
            loading_r <= loading;

            if (loader_do_valid)
                loader_addr <= loader_addr + 1'b1;

            // New image starts from byte zero
            if (loading && !loading_r) begin
                loader_addr <= '0;
                loaded      <= 1'b0;
            end

            if (!loading && loading_r)
                loaded <= 1'b1;                      // Image complete

            if (rom_hit)
                rom_addr_sd <= rom_hit_addr;
        end
    end

    // Holds the even byte
    always_ff @(posedge mclk) begin
        if (loader_do_valid)
            loader_do_r <= loader_do;
    end

    // Core runs only with a full image and an idle SDRAM
    always_ff @(posedge mclk) begin
        if (!resetn)
            enable <= 1'b0;
        else
            enable <= loaded && !sdram_busy;
    end

    // Bytes arriving outside a load would be lost
    a_valid_only_while_loading: assert property (
        @(posedge mclk) disable iff (!resetn)
        loader_do_valid |-> loading
    ) else $error("loader byte outside loading");

endmodule

//--- source/wram_channel.sv
module wram_channel import snes_mem_pkg::*; (
    input  logic                   mclk,
    input  logic                   resetn,

    // Core WRAM strobes
    input  logic [wram_addr_w-1:0] wram_addr,
    input  logic                   wram_ce_n,
    input  logic                   wram_rd_n,
    input  logic                   wram_we_n,

    output logic                   wram_hit,
    output logic                   wram_hit_we
);

    logic wram_rd;
    logic wram_wr;
    logic wram_rd_r;
    logic wram_wr_r;

    // Word address of the last access, bit 0 only picks the byte lane
    logic [wram_addr_w-1:1] wram_addr_sd;

    logic rd_rise;
    logic wr_rise;
    logic word_moved;

    assign wram_rd = !wram_ce_n && !wram_rd_n;
    assign wram_wr = !wram_ce_n && !wram_we_n;

    assign rd_rise = wram_rd && !wram_rd_r;
    assign wr_rise = wram_wr && !wram_wr_r;

    // Reads held across a word boundary need a fresh fetch
    assign word_moved = wram_rd && (wram_addr[wram_addr_w-1:1] != wram_addr_sd);

    assign wram_hit    = rd_rise || wr_rise || word_moved;
    assign wram_hit_we = wram_wr;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            wram_rd_r    <= 1'b0;
            wram_wr_r    <= 1'b0;
            wram_addr_sd <= '0;
        end else begin
            wram_rd_r <= wram_rd;
            wram_wr_r <= wram_wr;
            if (wram_hit)
                wram_addr_sd <= wram_addr[wram_addr_w-1:1];
        end
    end

    // Core never reads and writes WRAM at once
    a_rd_wr_exclusive: assert property (
        @(posedge mclk) disable iff (!resetn)
        !(wram_rd && wram_wr)
    ) else $error("WRAM read and write active together");

endmodule

//--- source/sdram_port_mux.sv
module sdram_port_mux import snes_mem_pkg::*; (
    input  logic                   mclk,
    input  logic                   resetn,

    // ROM channel request
    input  logic                   rom_hit,
    input  logic [rom_addr_w-1:0]  rom_hit_addr,
    input  logic                   rom_hit_we,
    input  logic [data_w-1:0]      rom_hit_din,

    // WRAM channel request, address and data straight from the core
    input  logic                   wram_hit,
    input  logic                   wram_hit_we,
    input  logic [wram_addr_w-1:0] wram_addr,
    input  logic [byte_w-1:0]      wram_d,

    // ROM read steering
    input  logic                   rom_addr0,
    input  logic                   rom_word,

    // Words returned by the SDRAM
    input  logic [data_w-1:0]      mem_port0,
    input  logic [data_w-1:0]      mem_port1,

    // SDRAM CPU port request
    output logic                   mem_req,
    output logic [word_addr_w-1:0] mem_addr,
    output logic [data_w-1:0]      mem_din,
    output logic [ds_w-1:0]        mem_ds,
    output logic                   mem_we,
    output logic                   mem_port,

    output logic [data_w-1:0]      rom_q,
    output logic [byte_w-1:0]      wram_q
);

    logic [rom_addr_w-1:0] wram_full_addr;
    logic                  any_hit;

    // Bank bits on top of the 17-bit WRAM address
    assign wram_full_addr = {wram_bank, wram_addr};
    assign any_hit        = rom_hit || wram_hit;

    // One toggle per access, no acknowledge expected
    always_ff @(posedge mclk) begin
        if (!resetn)
            mem_req <= 1'b0;
        else if (any_hit)
            mem_req <= !mem_req;
    end

    // Request fields, valid from the toggle edge until the next one
    always_ff @(posedge mclk) begin
        if (wram_hit) begin                          // WRAM wins a same-cycle clash
            mem_addr <= wram_full_addr[rom_addr_w-1:1];
            mem_din  <= {wram_d, wram_d};
            mem_ds   <= {wram_addr[0], !wram_addr[0]};
            mem_we   <= wram_hit_we;
            mem_port <= port_wram;
        end else if (rom_hit) begin
            mem_addr <= rom_hit_addr[rom_addr_w-1:1];
            mem_din  <= rom_hit_din;
            mem_ds   <= {ds_w{1'b1}};                 // Always a full word
            mem_we   <= rom_hit_we;
            mem_port <= port_rom;
        end
    end

    // Byte reads at odd addresses want the upper byte in the low lane
    assign rom_q = (rom_word || !rom_addr0) ? mem_port0
                                            : {mem_port0[byte_w-1:0], mem_port0[data_w-1:byte_w]};

    assign wram_q = wram_addr[0] ? mem_port1[data_w-1:byte_w] : mem_port1[byte_w-1:0];

    // Every toggle is caused by a hit one edge earlier
    a_req_after_hit: assert property (
        @(posedge mclk) disable iff (!resetn)
        $changed(mem_req) |-> $past(any_hit)
    ) else $error("mem_req toggled without a hit");

endmodule

//--- source/snes_mem_front.sv
module snes_mem_front import snes_mem_pkg::*; (
    input  logic                   mclk,
    input  logic                   resetn,

    // Core ROM bus
    input  logic [rom_addr_w-1:0]  rom_addr,
    input  logic                   rom_ce_n,
    input  logic                   rom_word,

    // Core WRAM bus
    input  logic [wram_addr_w-1:0] wram_addr,
    input  logic                   wram_ce_n,
    input  logic                   wram_rd_n,
    input  logic                   wram_we_n,
    input  logic [byte_w-1:0]      wram_d,

    // ROM image loader
    input  logic                   loading,
    input  logic [byte_w-1:0]      loader_do,
    input  logic                   loader_do_valid,

    // SDRAM controller side
    input  logic                   sdram_busy,
    input  logic [data_w-1:0]      mem_port0,
    input  logic [data_w-1:0]      mem_port1,

    output logic                   mem_req,
    output logic [word_addr_w-1:0] mem_addr,
    output logic [data_w-1:0]      mem_din,
    output logic [ds_w-1:0]        mem_ds,
    output logic                   mem_we,
    output logic                   mem_port,

    output logic [data_w-1:0]      rom_q,
    output logic [byte_w-1:0]      wram_q,

    output logic                   enable,
    output logic                   loaded
);

    logic                  rom_hit;
    logic [rom_addr_w-1:0] rom_hit_addr;
    logic                  rom_hit_we;
    logic [data_w-1:0]     rom_hit_din;

    logic                  wram_hit;
    logic                  wram_hit_we;

    rom_channel u_rom_channel (
        .mclk            (mclk),
        .resetn          (resetn),
        .loading         (loading),
        .loader_do       (loader_do),
        .loader_do_valid (loader_do_valid),
        .rom_addr        (rom_addr),
        .rom_ce_n        (rom_ce_n),
        .sdram_busy      (sdram_busy),
        .rom_hit         (rom_hit),
        .rom_hit_addr    (rom_hit_addr),
        .rom_hit_we      (rom_hit_we),
        .rom_hit_din     (rom_hit_din),
        .loaded          (loaded),
        .enable          (enable)
    );

    wram_channel u_wram_channel (
        .mclk        (mclk),
        .resetn      (resetn),
        .wram_addr   (wram_addr),
        .wram_ce_n   (wram_ce_n),
        .wram_rd_n   (wram_rd_n),
        .wram_we_n   (wram_we_n),
        .wram_hit    (wram_hit),
        .wram_hit_we (wram_hit_we)
    );

    // Single CPU port shared by both channels
    sdram_port_mux u_sdram_port_mux (
        .mclk         (mclk),
        .resetn       (resetn),
        .rom_hit      (rom_hit),
        .rom_hit_addr (rom_hit_addr),
        .rom_hit_we   (rom_hit_we),
        .rom_hit_din  (rom_hit_din),
        .wram_hit     (wram_hit),
        .wram_hit_we  (wram_hit_we),
        .wram_addr    (wram_addr),
        .wram_d       (wram_d),
        .rom_addr0    (rom_addr[0]),
        .rom_word     (rom_word),
        .mem_port0    (mem_port0),
        .mem_port1    (mem_port1),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_din      (mem_din),
        .mem_ds       (mem_ds),
        .mem_we       (mem_we),
        .mem_port     (mem_port),
        .rom_q        (rom_q),
        .wram_q       (wram_q)
    );

endmodule

//--- dv/tb_snes_mem_front.sv
module tb_snes_mem_front import snes_mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int load_bytes  = 64;
    localparam int rom_reads   = 12;
    localparam int wram_ops    = 8;
    localparam int wait_limit  = 16;    // Cycles to wait for a request toggle
    localparam int stim_cycles = 20 + load_bytes * 2 + rom_reads * 8 + wram_ops * 12 + 40;

    logic                   mclk;
    logic                   resetn;
    logic [rom_addr_w-1:0]  rom_addr;
    logic                   rom_ce_n;
    logic                   rom_word;
    logic [wram_addr_w-1:0] wram_addr;
    logic                   wram_ce_n;
    logic                   wram_rd_n;
    logic                   wram_we_n;
    logic [byte_w-1:0]      wram_d;
    logic                   loading;
    logic [byte_w-1:0]      loader_do;
    logic                   loader_do_valid;
    logic                   sdram_busy;
    logic [data_w-1:0]      mem_port0 = '0;
    logic [data_w-1:0]      mem_port1 = '0;

    logic                   mem_req;
    logic [word_addr_w-1:0] mem_addr;
    logic [data_w-1:0]      mem_din;
    logic [ds_w-1:0]        mem_ds;
    logic                   mem_we;
    logic                   mem_port;
    logic [data_w-1:0]      rom_q;
    logic [byte_w-1:0]      wram_q;
    logic                   enable;
    logic                   loaded;

    logic [31:0]            lfsr;
    logic [byte_w-1:0]      rom_image [load_bytes];
    logic [byte_w-1:0]      wram_shadow [int];
    logic [data_w-1:0]      sdram_mem [int];
    logic                   model_req;

    // Data checks armed by the stimulus
    logic                   rom_chk;
    logic [data_w-1:0]      exp_rom_q;
    logic                   wram_chk;
    logic [byte_w-1:0]      exp_wram_q;

    snes_mem_front u_snes_mem_front (.*);

    initial begin
        mclk = 1'b0;
        forever #2 mclk = !mclk;
    end

    // Taps 32, 22, 2, 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_w,
                                                      input logic [data_w-1:0] din,
                                                      input logic [ds_w-1:0]   ds);
        logic [data_w-1:0] w;
        w = old_w;
        if (ds[0])
            w[byte_w-1:0] = din[byte_w-1:0];
        if (ds[1])
            w[data_w-1:byte_w] = din[data_w-1:byte_w];
        return w;
    endfunction

    // SDRAM model, serves each toggle one edge after it appears
    always @(posedge mclk) begin
        if (!resetn) begin
            model_req <= 1'b0;
            mem_port0 <= '0;
            mem_port1 <= '0;
        end else if (mem_req != model_req) begin
            model_req <= mem_req;
            if (mem_we) begin
                sdram_mem[int'(mem_addr)] = merge_bytes(
                    sdram_mem.exists(int'(mem_addr)) ? sdram_mem[int'(mem_addr)] : '0,
                    mem_din, mem_ds);
            end else if (mem_port == port_rom) begin
                mem_port0 <= sdram_mem.exists(int'(mem_addr)) ? sdram_mem[int'(mem_addr)] : '0;
            end else begin
                mem_port1 <= sdram_mem.exists(int'(mem_addr)) ? sdram_mem[int'(mem_addr)] : '0;
            end
        end
    end

    // Reference state built from input events only
    logic [rom_addr_w-1:0]  sh_cnt;
    logic [rom_addr_w-1:0]  sh_last_rom;
    logic [byte_w-1:0]      sh_prev_byte;
    logic [wram_addr_w-1:1] sh_last_word;
    logic                   sh_loading_r;
    logic                   sh_rd_r;
    logic                   sh_wr_r;
    logic                   exp_req;
    logic                   exp_fresh;
    logic                   exp_loaded;
    logic                   exp_enable;
    logic                   seen_event;
    logic [word_addr_w-1:0] exp_addr;
    logic [data_w-1:0]      exp_din;
    logic [ds_w-1:0]        exp_ds;
    logic                   exp_we;
    logic                   exp_port;

    logic                   ev_rom;
    logic                   ev_wram;
    logic [rom_addr_w-1:0]  ev_rom_addr;
    logic                   rd_lvl;
    logic                   wr_lvl;
    logic [rom_addr_w-1:0]  wram_full;

    assign rd_lvl      = !wram_ce_n && !wram_rd_n;
    assign wr_lvl      = !wram_ce_n && !wram_we_n;
    assign ev_rom      = (loading && loader_do_valid && sh_cnt[0])
                      || (!loading && !rom_ce_n && rom_addr != sh_last_rom);
    assign ev_rom_addr = loading ? sh_cnt : rom_addr;
    assign ev_wram     = (rd_lvl && !sh_rd_r) || (wr_lvl && !sh_wr_r)
                      || (rd_lvl && wram_addr[wram_addr_w-1:1] != sh_last_word);
    assign wram_full   = {wram_bank, wram_addr};

    always @(posedge mclk) begin
        if (!resetn) begin
            sh_cnt       <= '0;
            sh_last_rom  <= '0;
            sh_prev_byte <= '0;
            sh_last_word <= '0;
            sh_loading_r <= 1'b0;
            sh_rd_r      <= 1'b0;
            sh_wr_r      <= 1'b0;
            exp_req      <= 1'b0;
            exp_fresh    <= 1'b0;
            exp_loaded   <= 1'b0;
            exp_enable   <= 1'b0;
            seen_event   <= 1'b0;
        end else begin
            exp_fresh <= ev_rom || ev_wram;
            if (ev_rom || ev_wram) begin
                exp_req    <= !exp_req;
                seen_event <= 1'b1;
            end
            if (ev_wram) begin                       // WRAM beats ROM
                exp_addr <= wram_full[rom_addr_w-1:1];
                exp_din  <= {wram_d, wram_d};
                exp_ds   <= {wram_addr[0], !wram_addr[0]};
                exp_we   <= wr_lvl;
                exp_port <= port_wram;
            end else if (ev_rom) begin
                exp_addr <= ev_rom_addr[rom_addr_w-1:1];
                exp_din  <= {loader_do, sh_prev_byte};
                exp_ds   <= 2'b11;
                exp_we   <= loading;
                exp_port <= port_rom;
            end
            if (ev_rom)
                sh_last_rom <= ev_rom_addr;
            if (ev_wram)
                sh_last_word <= wram_addr[wram_addr_w-1:1];
            sh_rd_r      <= rd_lvl;
            sh_wr_r      <= wr_lvl;
            sh_loading_r <= loading;
            if (loader_do_valid) begin
                sh_cnt       <= sh_cnt + rom_addr_w'(1);
                sh_prev_byte <= loader_do;
            end
            if (loading && !sh_loading_r) begin      // Fresh image
                sh_cnt     <= '0;
                exp_loaded <= 1'b0;
            end
            if (!loading && sh_loading_r)
                exp_loaded <= 1'b1;
            exp_enable <= exp_loaded && !sdram_busy;
        end
    end

    task automatic report_error(input string msg);
        $display("FAIL %0d ns: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // Outputs sampled mid-cycle where everything is settled
    a_idle: assert property (@(negedge mclk) disable iff (!resetn)
        !seen_event |-> !mem_req && !loaded && !enable)
        else report_error("status not idle after reset");
    a_req: assert property (@(negedge mclk) disable iff (!resetn) mem_req == exp_req)
        else report_error("mem_req toggle missing or unexpected");
    a_fields: assert property (@(negedge mclk) disable iff (!resetn)
        exp_fresh |-> mem_addr == exp_addr && mem_ds == exp_ds
                      && mem_we == exp_we && mem_port == exp_port)
        else report_error("request address or control wrong");
    a_wdata: assert property (@(negedge mclk) disable iff (!resetn)
        exp_fresh && exp_we |-> mem_din == exp_din)
        else report_error("write data wrong");
    a_loaded: assert property (@(negedge mclk) disable iff (!resetn) loaded == exp_loaded)
        else report_error("loaded wrong");
    a_enable: assert property (@(negedge mclk) disable iff (!resetn) enable == exp_enable)
        else report_error("enable wrong");
    a_rom_q: assert property (@(negedge mclk) disable iff (!resetn)
        rom_chk |-> rom_q == exp_rom_q)
        else report_error("rom_q wrong");
    a_wram_q: assert property (@(negedge mclk) disable iff (!resetn)
        wram_chk |-> wram_q == exp_wram_q)
        else report_error("wram_q wrong");

    task automatic step_clock();
        @(posedge mclk);
        #1;
    endtask

    task automatic wait_toggle(input string what);
        logic start;
        int   n;
        start = mem_req;
        n     = 0;
        while (mem_req == start) begin
            @(negedge mclk);
            n++;
            if (n > wait_limit) begin
                $display("Timed out waiting for the %s request", what);
                $display("sim failed");
                $fatal(1);
            end
        end
    endtask

    task automatic wait_enable();
        int n;
        n = 0;
        while (!enable) begin
            @(negedge mclk);
            n++;
            if (n > wait_limit) begin
                $display("Timed out waiting for the core enable");
                $display("sim failed");
                $fatal(1);
            end
        end
    endtask

    initial begin
        #(stim_cycles * 4 + 400);
        $display("Watchdog expired before the stimulus finished");
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        int               a;
        int               last_rom;
        int               wa [wram_ops];
        logic [data_w-1:0] w;

        lfsr            = 32'h254e;
        resetn          = 1'b0;
        rom_addr        = '0;
        rom_ce_n        = 1'b1;
        rom_word        = 1'b0;
        wram_addr       = '0;
        wram_ce_n       = 1'b1;
        wram_rd_n       = 1'b1;
        wram_we_n       = 1'b1;
        wram_d          = '0;
        loading         = 1'b0;
        loader_do       = '0;
        loader_do_valid = 1'b0;
        sdram_busy      = 1'b0;
        rom_chk         = 1'b0;
        exp_rom_q       = '0;
        wram_chk        = 1'b0;
        exp_wram_q      = '0;

        repeat (10) @(posedge mclk);
        #1;
        resetn = 1'b1;
        repeat (3) step_clock();

        // ROM image stream with random gaps and a busy SDRAM now and then
        loading = 1'b1;
        step_clock();
        for (int i = 0; i < load_bytes; i++) begin
            loader_do       = byte_w'(rand_bits(8));
            rom_image[i]    = loader_do;
            loader_do_valid = 1'b1;
            sdram_busy      = 1'(rand_bits(1));
            step_clock();
            loader_do_valid = 1'b0;
            if (rand_bits(1) != 0)
                step_clock();
        end
        loading    = 1'b0;
        sdram_busy = 1'b0;
        wait_enable();

        // Enable drops while the SDRAM is busy
        step_clock();
        sdram_busy = 1'b1;
        repeat (3) step_clock();
        sdram_busy = 1'b0;
        wait_enable();

        last_rom = load_bytes - 1;                   // Last loader write address
        for (int k = 0; k < rom_reads; k++) begin
            a = int'(rand_bits(6));
            if (a == last_rom)
                a ^= 1;
            last_rom = a;
            step_clock();
            rom_addr = rom_addr_w'(a);
            rom_word = 1'(rand_bits(1));
            rom_ce_n = 1'b0;
            wait_toggle("ROM read");
            step_clock();
            w         = {rom_image[a | 1], rom_image[a & ~1]};
            exp_rom_q = (rom_word || a % 2 == 0) ? w : {w[byte_w-1:0], w[data_w-1:byte_w]};
            rom_chk   = 1'b1;
            step_clock();
            rom_chk = 1'b0;
            step_clock();                            // Same address, no new request
            rom_ce_n = 1'b1;
        end
        step_clock();

        for (int k = 0; k < wram_ops; k++) begin
            wa[k]     = int'(rand_bits(17));
            wram_addr = wram_addr_w'(wa[k]);
            wram_d    = byte_w'(rand_bits(8));
            wram_shadow[wa[k]] = wram_d;
            wram_ce_n = 1'b0;
            wram_we_n = 1'b0;
            wait_toggle("WRAM write");
            step_clock();
            wram_we_n = 1'b1;
            wram_ce_n = 1'b1;
            step_clock();
        end

        for (int k = 0; k < wram_ops; k++) begin
            wram_addr = wram_addr_w'(wa[k]);
            wram_ce_n = 1'b0;
            wram_rd_n = 1'b0;
            wait_toggle("WRAM read");
            step_clock();
            exp_wram_q = wram_shadow[wa[k]];
            wram_chk   = 1'b1;
            step_clock();
            wram_chk  = 1'b0;
            wram_rd_n = 1'b1;
            wram_ce_n = 1'b1;
            step_clock();
        end

        repeat (4) step_clock();
        $display("sim passed");
        $finish;
    end

endmodule

//--- snes_mem_front.f
source/snes_mem_pkg.sv
source/rom_channel.sv
source/wram_channel.sv
source/sdram_port_mux.sv
source/snes_mem_front.sv
dv/tb_snes_mem_front.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f snes_mem_front.f \
    --top-module tb_snes_mem_front \
    -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
